/* daq_optical_tx.f */
+incdir+hw
hw/daq_tx_pkg.sv
hw/daq_link_reset.sv
hw/daq_frame_seq.sv
hw/daq_symbol_rom.sv
hw/daq_crc32.sv
hw/daq_word_mux.sv
hw/daq_optical_tx.sv
dv/daq_optical_tx_tb.sv

/* dv/daq_optical_tx_tb.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_optical_tx_tb
	import daq_tx_pkg::*;
();

	localparam int MAX_WORDS   = 32; // Longest packet
	localparam int NUM_PKTS    = 6;  // Back-to-back packets after lock
	localparam int DATA_START  = `DAQ_PREAMBLE_WORDS + 2; // After SOP, preamble and SOF
	localparam int FRAME_EXTRA = DATA_START + 4; // Plus CRC pair, EOP, carrier extend
	localparam int READY_WAIT  = 40;
	localparam int DRAIN_WAIT  = 200;

	localparam tx_word_t IDLE_W = '{data: {`DAQ_D16_2, `DAQ_K28_5}, charisk: 2'b01};
	localparam tx_word_t SOP_W  = '{data: {`DAQ_PRMBL, `DAQ_K27_7}, charisk: 2'b01};
	localparam tx_word_t CEXT_W = '{data: {`DAQ_K23_7, `DAQ_K23_7}, charisk: 2'b11};

	typedef logic [`DAQ_WORD_W-1:0] data_q_t[$];
	typedef tx_word_t frame_q_t[$];

	logic                   usr_clk_wordwise;
	logic                   arst;
	logic                   pll_lock_i;
	logic                   txd_valid_i;
	logic [`DAQ_WORD_W-1:0] txd_i;
	logic                   txd_ready_o;
	tx_word_t               tx_word_o;

	integer  seed;
	int      word_errs, gap_errs, count_errs, misc_errs; // Tallies by kind of check
	int      transfers, ready_cycles;                    // Handshake counts
	int      pkts_sent, frames_done, words_sent;
	bit      timed_out;
	int      exp_len[$]; // Packet lengths with the oldest first
	data_q_t exp_data;   // Their words in send order

	daq_optical_tx DUT (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock_i),
		.txd_i            (txd_i),
		.txd_valid_i      (txd_valid_i),
		.txd_ready_o      (txd_ready_o),
		.tx_word_o        (tx_word_o)
	);

	initial usr_clk_wordwise = 1'b0;
	always #5 usr_clk_wordwise = ~usr_clk_wordwise; // 10 ns period

	////////////////////////////////////////
	// Reference frame model
	////////////////////////////////////////

	// Complement of the bitwise reflected CRC-32 with the low byte of each word first
	function automatic logic [31:0] packet_crc(input data_q_t words);
		logic [31:0] c;
		logic [7:0]  b;
		c = 32'hFFFF_FFFF;
		foreach (words[w])
			for (int h = 0; h < 2; h++)
			begin
				b = h ? words[w][15:8] : words[w][7:0];
				for (int i = 0; i < 8; i++)
					c = (c >> 1) ^ ((c[0] ^ b[i]) ? 32'hEDB8_8320 : 32'h0);
			end
		return ~c;
	endfunction

	// Word at position idx of the frame for this packet
	function automatic tx_word_t expected_word(input data_q_t words, input int idx);
		tx_word_t    w;
		logic [31:0] crc;
		int          n;
		n   = words.size();
		crc = packet_crc(words);
		w   = IDLE_W; // Past the end
		if (idx == 0)
			w = SOP_W;
		else if (idx <= `DAQ_PREAMBLE_WORDS)
			w = '{data: {`DAQ_PRMBL, `DAQ_PRMBL}, charisk: 2'b00};
		else if (idx == DATA_START - 1)
			w = '{data: {`DAQ_SOF, `DAQ_PRMBL}, charisk: 2'b00};
		else if (idx < DATA_START + n)
			w = '{data: words[idx - DATA_START], charisk: 2'b00};
		else if (idx == DATA_START + n)
			w = '{data: crc[15:0], charisk: 2'b00}; // Low half goes first
		else if (idx == DATA_START + n + 1)
			w = '{data: crc[31:16], charisk: 2'b00};
		else if (idx == DATA_START + n + 2)
			w = '{data: {`DAQ_K23_7, `DAQ_K29_7}, charisk: 2'b11}; // /T/ /R/
		else if (idx == DATA_START + n + 3)
			w = CEXT_W;
		return w;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_word(input tx_word_t got, input tx_word_t exp, input string name);
		if (got !== exp)
		begin
			word_errs++;
			$display("FAIL %0t %s got %h/%b expected %h/%b", $time, name,
				got.data, got.charisk, exp.data, exp.charisk);
		end
	endtask

	task automatic check_gap(input int idles);
		if (idles < `DAQ_IPG_WORDS)
		begin
			gap_errs++;
			$display("FAIL %0t idle gap got %0d expected at least %0d", $time, idles,
				`DAQ_IPG_WORDS);
		end
	endtask

	task automatic match_count(input int got, input int exp, input string name);
		if (got != exp)
		begin
			count_errs++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Checks one collected frame against the oldest packet sent
	task automatic score_frame(input frame_q_t frame);
		data_q_t words;
		int      n;
		if (exp_len.size() == 0)
		begin
			misc_errs++;
			$display("A frame left the DUT at %0t with no packet sent", $time);
		end
		else
		begin
			n = exp_len.pop_front();
			for (int i = 0; i < n; i++)
				words.push_back(exp_data.pop_front());
			match_count(frame.size(), n + FRAME_EXTRA, "frame length");
			foreach (frame[i])
				check_word(frame[i], expected_word(words, i),
					$sformatf("tx_word_o packet %0d word %0d", frames_done, i));
			frames_done++;
		end
	endtask

	// Drives a random packet and drops valid after its last transfer
	task automatic send_packet(input int n);
		data_q_t     words;
		logic [31:0] r;
		int          waited;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			words.push_back(r[15:0]);
		end
		exp_len.push_back(n);
		foreach (words[i])
			exp_data.push_back(words[i]);
		pkts_sent++;
		words_sent += n;
		@(negedge usr_clk_wordwise);
		txd_valid_i = 1'b1;
		txd_i       = words[0];
		waited      = 0;
		while (!txd_ready_o && !timed_out) // Preamble runs before ready
		begin
			@(negedge usr_clk_wordwise);
			waited++;
			if (waited > READY_WAIT)
			begin
				timed_out = 1'b1;
				misc_errs++;
				$display("Timeout waiting for txd_ready_o on packet %0d", pkts_sent - 1);
			end
		end
		for (int i = 1; i < n && !timed_out; i++)
		begin
			@(negedge usr_clk_wordwise);
			txd_i = words[i]; // One word per cycle with no back-pressure
		end
		@(negedge usr_clk_wordwise);
		txd_valid_i = 1'b0; // Ends the data phase
	endtask

	////////////////////////////////////////
	// Handshake counter and stream monitor
	////////////////////////////////////////

	initial
	begin
		logic rdy;
		forever
		begin
			@(negedge usr_clk_wordwise);
			rdy = txd_ready_o; // Settled since the rising edge
			@(posedge usr_clk_wordwise);
			if (!arst && rdy)
			begin
				ready_cycles++;
				if (txd_valid_i)
					transfers++;
			end
		end
	end

	initial
	begin
		frame_q_t frame;
		int       idle_run;
		bit       in_frame;
		bit       seen_frame;
		idle_run   = 0;
		in_frame   = 1'b0;
		seen_frame = 1'b0;
		forever
		begin
			@(negedge usr_clk_wordwise);
			if (in_frame)
			begin
				frame.push_back(tx_word_o);
				if (tx_word_o === CEXT_W || frame.size() > MAX_WORDS + FRAME_EXTRA)
				begin
					score_frame(frame);
					in_frame   = 1'b0;
					idle_run   = 0;
					seen_frame = 1'b1;
				end
			end
			else if (tx_word_o === SOP_W)
			begin
				if (seen_frame)
					check_gap(idle_run);
				frame.delete();
				frame.push_back(tx_word_o);
				in_frame = 1'b1;
			end
			else if (tx_word_o === IDLE_W)
				idle_run++;
			else
			begin
				misc_errs++;
				$display("Non-idle word %h/%b between packets at %0t", tx_word_o.data,
					tx_word_o.charisk, $time);
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		int          waited;
		seed        = 11;
		arst        = 1'b1;
		pll_lock_i  = 1'b0;
		txd_valid_i = 1'b0;
		txd_i       = '0;
		repeat (16) @(posedge usr_clk_wordwise);
		@(negedge usr_clk_wordwise);
		arst        = 1'b0;
		txd_valid_i = 1'b1; // Request while the PLL is still unlocked
		repeat (40)
		begin
			@(negedge usr_clk_wordwise);
			if (txd_ready_o)
			begin
				misc_errs++;
				$display("txd_ready_o high at %0t with the PLL unlocked", $time);
			end
			check_word(tx_word_o, IDLE_W, "tx_word_o before lock");
		end
		pll_lock_i = 1'b1; // First packet starts here
		for (int p = 0; p < NUM_PKTS && !timed_out; p++)
		begin
			r = $random(seed);
			send_packet(int'(r[4:0]) + 1); // 1 to MAX_WORDS words
		end
		waited = 0;
		while (frames_done < pkts_sent && !timed_out)
		begin
			@(negedge usr_clk_wordwise);
			waited++;
			if (waited > DRAIN_WAIT)
			begin
				timed_out = 1'b1;
				misc_errs++;
				$display("Timeout waiting for the last frame on tx_word_o");
			end
		end
		match_count(transfers, words_sent, "accepted transfers");
		match_count(ready_cycles, words_sent + pkts_sent, "txd_ready_o high cycles");
		$display("Errors %0d word, %0d gap, %0d count, %0d other over %0d packets",
			word_errs, gap_errs, count_errs, misc_errs, pkts_sent);
		if (word_errs + gap_errs + count_errs + misc_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hw/daq_crc32.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_crc32
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic                   clear_i, // Load the seed
	input  logic                   calc_i,  // Fold data_i in
	input  logic [`DAQ_WORD_W-1:0] data_i,  // Low byte first on the wire
	output logic [31:0]            crc_o    // Complemented, low byte sent first
);

	logic [31:0] crc_q;

	////////////////////////////////////////
	// One octet, LSB first
	////////////////////////////////////////

	function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
		input logic [7:0] octet);
		logic [31:0] c;
		logic        fb;
		c = crc_in;
		for (int i = 0; i < 8; i++)
		begin
			fb = c[0] ^ octet[i]; // Feedback bit
			c  = (c >> 1) ^ (`DAQ_CRC_POLY & {32{fb}});
		end
		return c;
	endfunction

	// Two octets per clock, low byte then high byte
	function automatic logic [31:0] crc_word(input logic [31:0] crc_in,
		input logic [`DAQ_WORD_W-1:0] word);
		logic [31:0] c;
		c = crc_byte(crc_in, word[7:0]);
		c = crc_byte(c, word[15:8]);
		return c;
	endfunction

	////////////////////////////////////////
	// CRC register
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_q <= `DAQ_CRC_INIT; // Holds the seed after reset
		else if (clear_i)
			crc_q <= `DAQ_CRC_INIT;
		else if (calc_i)
			crc_q <= crc_word(crc_q, data_i);
	end

	// Reflected register is already in wire order
	assign crc_o = ~crc_q;

endmodule

/* hw/daq_frame_seq.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_frame_seq
	import daq_tx_pkg::*;
(
	input  logic      usr_clk_wordwise,
	input  logic      arst,
	input  logic      link_up_i,   // Stretched reset released and PLL locked
	input  logic      txd_valid_i, // Source requests or continues a packet
	output logic      txd_ready_o, // High through the data phase
	output seq_ctrl_t ctrl_o       // Control for table, CRC and mux
);

	// Counter spans the longer of preamble and gap
	localparam int CNT_MAX = (`DAQ_IPG_WORDS > `DAQ_PREAMBLE_WORDS) ?
		`DAQ_IPG_WORDS : `DAQ_PREAMBLE_WORDS;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	frame_state_e state_q, state_d;
	frame_state_e state_eff; // State that owns this cycle's word
	logic [CNT_W-1:0] cnt_q, cnt_d;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end
		else
		begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
		end
	end

	// Valid low in the data phase ends the packet
	// That same slot already carries the CRC low half
	always_comb
	begin
		state_eff = state_q;
		if (state_q == ST_DATA && !txd_valid_i)
			state_eff = ST_CRC_LO;
	end

	assign txd_ready_o = (state_q == ST_DATA); // No back-pressure inside a packet

	////////////////////////////////////////
	// Next state and per-cycle control
	////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		cnt_d   = '0;
		ctrl_o  = '{sym_sel: SYM_IDLE, src: SRC_SYMBOL, crc_clear: 1'b0, crc_calc: 1'b0};
		case (state_eff)
			ST_IDLE:
			begin
				if (link_up_i && txd_valid_i) // Frame needs link and a request
					state_d = ST_SOP;
			end
			ST_SOP:
			begin
				ctrl_o.sym_sel = SYM_SOP_PRE;
				state_d        = ST_PREAMBLE;
			end
			ST_PREAMBLE:
			begin
				ctrl_o.sym_sel = SYM_PREAMBLE;
				if (cnt_q == CNT_W'(`DAQ_PREAMBLE_WORDS - 1))
					state_d = ST_SOF;
				else
					cnt_d = cnt_q + 1'b1;
			end
			ST_SOF:
			begin
				ctrl_o.sym_sel   = SYM_SOF_PRE;
				ctrl_o.crc_clear = 1'b1; // Seed before the first data word
				state_d          = ST_DATA;
			end
			ST_DATA:
			begin
				ctrl_o.src      = SRC_DATA; // Valid is high here, word transfers
				ctrl_o.crc_calc = 1'b1;
			end
			ST_CRC_LO:
			begin
				ctrl_o.src = SRC_CRC_LO;
				state_d    = ST_CRC_HI;
			end
			ST_CRC_HI:
			begin
				ctrl_o.src = SRC_CRC_HI;
				state_d    = ST_EOP;
			end
			ST_EOP:
			begin
				ctrl_o.sym_sel = SYM_EOP; // /T/ /R/
				state_d        = ST_CEXT;
			end
			ST_CEXT:
			begin
				ctrl_o.sym_sel = SYM_CARRIER_EXT;
				state_d        = ST_GAP;
			end
			ST_GAP:
			begin
				if (cnt_q == CNT_W'(`DAQ_IPG_WORDS - 1)) // Minimum gap served
					state_d = ST_IDLE;
				else
					cnt_d = cnt_q + 1'b1;
			end
			default: state_d = ST_IDLE;
		endcase
	end

endmodule

/* hw/daq_link_reset.sv */
`timescale 1ns/10ps

module daq_link_reset
(
	input  logic usr_clk_wordwise,
	input  logic arst,
	input  logic pll_lock_i, // Transmit PLL lock
	output logic link_up_o   // Link may carry frames
);

	logic [3:0] stretch_q; // Reset stretch, ones while held

	// Set by arst, zeros walk in only while the PLL is locked
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			stretch_q <= 4'b1111;
		else if (pll_lock_i)
			stretch_q <= {stretch_q[2:0], 1'b0};
	end

	// Up once the zero reaches the end
	// Lock loss drops it at once
	assign link_up_o = ~stretch_q[3] & pll_lock_i;

endmodule

/* hw/daq_optical_tx.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_optical_tx
	import daq_tx_pkg::*;
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic                   pll_lock_i,  // Transmit PLL lock
	input  logic [`DAQ_WORD_W-1:0] txd_i,       // DAQ word
	input  logic                   txd_valid_i, // Packet request and data valid
	output logic                   txd_ready_o, // Data phase running
	output tx_word_t               tx_word_o    // Framed word with K flags
);

	logic        link_up;  // Link reset released
	seq_ctrl_t   ctrl;     // Per-cycle control
	tx_word_t    sym_word; // Table output
	logic [31:0] crc;      // Complemented CRC

	////////////////////////////////////////
	// Reset and sequencing
	////////////////////////////////////////

	daq_link_reset u_link_reset (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock_i),
		.link_up_o        (link_up)
	);

	daq_frame_seq u_frame_seq (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.link_up_i        (link_up),
		.txd_valid_i      (txd_valid_i),
		.txd_ready_o      (txd_ready_o),
		.ctrl_o           (ctrl)
	);

	////////////////////////////////////////
	// Word path
	////////////////////////////////////////

	daq_symbol_rom u_symbol_rom (
		.usr_clk_wordwise (usr_clk_wordwise),
		.sym_sel_i        (ctrl.sym_sel),
		.sym_o            (sym_word)
	);

	daq_crc32 u_crc32 (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.clear_i          (ctrl.crc_clear),
		.calc_i           (ctrl.crc_calc),
		.data_i           (txd_i),
		.crc_o            (crc)
	);

	daq_word_mux u_word_mux (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.src_i            (ctrl.src),
		.sym_i            (sym_word),
		.txd_i            (txd_i),
		.crc_i            (crc),
		.tx_word_o        (tx_word_o)
	);

endmodule

/* hw/daq_symbol_rom.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_symbol_rom
	import daq_tx_pkg::*;
(
	input  logic     usr_clk_wordwise,
	input  sym_sel_e sym_sel_i, // Entry for this cycle
	output tx_word_t sym_o      // Ordered-set word, one cycle later
);

	////////////////////////////////////////
	// Ordered-set table
	////////////////////////////////////////

	// Octets listed high then low, low goes out first
	always_ff @(posedge usr_clk_wordwise)
	begin
		case (sym_sel_i)
			SYM_IDLE:        sym_o <= TX_IDLE_WORD;
			SYM_SOP_PRE:     sym_o <= '{data: {`DAQ_PRMBL, `DAQ_K27_7}, charisk: 2'b01};
			SYM_PREAMBLE:    sym_o <= '{data: {`DAQ_PRMBL, `DAQ_PRMBL}, charisk: 2'b00};
			SYM_SOF_PRE:     sym_o <= '{data: {`DAQ_SOF, `DAQ_PRMBL}, charisk: 2'b00};
			SYM_EOP:         sym_o <= '{data: {`DAQ_K23_7, `DAQ_K29_7}, charisk: 2'b11};
			SYM_CARRIER_EXT: sym_o <= '{data: {`DAQ_K23_7, `DAQ_K23_7}, charisk: 2'b11};
			default:         sym_o <= TX_IDLE_WORD; // Unused codes send idle
		endcase
	end

endmodule

/* hw/daq_tx_cfg.svh */
`ifndef DAQ_TX_CFG_SVH
`define DAQ_TX_CFG_SVH

////////////////////////////////////////
// Word format
////////////////////////////////////////

`define DAQ_WORD_W 16 // Data word width, two octets per clock

////////////////////////////////////////
// Octet codes
////////////////////////////////////////

`define DAQ_K28_5 8'hBC // Comma, first octet of idle
`define DAQ_D16_2 8'h50 // Second idle octet, keeps disparity
`define DAQ_K27_7 8'hFB // /S/ start of packet
`define DAQ_K29_7 8'hFD // /T/ end of packet
`define DAQ_K23_7 8'hF7 // /R/ carrier extend
`define DAQ_PRMBL 8'h55 // Preamble octet
`define DAQ_SOF   8'hD5 // Start of frame delimiter

////////////////////////////////////////
// Framing lengths, in words
////////////////////////////////////////

`define DAQ_PREAMBLE_WORDS 2 // All-preamble words between /S/ and SOF
`define DAQ_IPG_WORDS      6 // Minimum idles after carrier extend

// Ethernet CRC-32, LSB-first form
`define DAQ_CRC_POLY 32'hEDB8_8320
`define DAQ_CRC_INIT 32'hFFFF_FFFF

`endif

/* hw/daq_tx_pkg.sv */
`include "daq_tx_cfg.svh"

package daq_tx_pkg;

	////////////////////////////////////////
	// Link word
	////////////////////////////////////////

	// Low byte goes on the wire first, charisk[0] tags it
	typedef struct packed {
		logic [`DAQ_WORD_W-1:0] data;
		logic [1:0]             charisk;
	} tx_word_t;

	// Entries of the ordered-set table
	typedef enum logic [2:0] {
		SYM_IDLE,        // K28.5 D16.2
		SYM_SOP_PRE,     // /S/ plus first preamble octet
		SYM_PREAMBLE,    // Two preamble octets
		SYM_SOF_PRE,     // Last preamble octet plus SOF
		SYM_EOP,         // /T/ /R/
		SYM_CARRIER_EXT  // /R/ /R/
	} sym_sel_e;

	// Source of the outgoing word
	typedef enum logic [1:0] {
		SRC_SYMBOL,
		SRC_DATA,
		SRC_CRC_LO,
		SRC_CRC_HI
	} word_src_e;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SOP,
		ST_PREAMBLE,
		ST_SOF,
		ST_DATA,
		ST_CRC_LO,
		ST_CRC_HI,
		ST_EOP,
		ST_CEXT,
		ST_GAP
	} frame_state_e;

	// Per-cycle control from the sequencer
	typedef struct packed {
		sym_sel_e  sym_sel;   // Table entry
		word_src_e src;       // Output word source
		logic      crc_clear; // Seed the CRC
		logic      crc_calc;  // Fold current data word into CRC
	} seq_ctrl_t;

	// Idle word, used by the table and as the output reset value
	localparam tx_word_t TX_IDLE_WORD = '{data: {`DAQ_D16_2, `DAQ_K28_5}, charisk: 2'b01};

endpackage

/* hw/daq_word_mux.sv */
`timescale 1ns/10ps
`include "daq_tx_cfg.svh"

module daq_word_mux
	import daq_tx_pkg::*;
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  word_src_e              src_i,    // Source chosen by the sequencer
	input  tx_word_t               sym_i,    // Table word, already one stage late
	input  logic [`DAQ_WORD_W-1:0] txd_i,    // DAQ data
	input  logic [31:0]            crc_i,    // Final CRC, wire order
	output tx_word_t               tx_word_o // Word to the 8b10b encoder
);

	word_src_e              src_q;  // Source, aligned with the table
	logic [`DAQ_WORD_W-1:0] data_q; // Data word, aligned with the table

	////////////////////////////////////////
	// Alignment stage
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			src_q <= SRC_SYMBOL;
		else
			src_q <= src_i;
	end

	always_ff @(posedge usr_clk_wordwise)
	begin
		data_q <= txd_i; // Payload, captured on every edge
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			tx_word_o <= TX_IDLE_WORD;
		else
			case (src_q)
				SRC_DATA:   tx_word_o <= '{data: data_q, charisk: 2'b00};
				SRC_CRC_LO: tx_word_o <= '{data: crc_i[15:0], charisk: 2'b00};  // Sent first
				SRC_CRC_HI: tx_word_o <= '{data: crc_i[31:16], charisk: 2'b00};
				default:    tx_word_o <= sym_i; // Ordered set from the table
			endcase
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the DAQ optical transmit testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=daq_optical_tx_sim

# Build from the file list
verilator --binary --timing -j 0 -f daq_optical_tx.f \
	--top-module daq_optical_tx_tb -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Run and keep a log
./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
